/* hdl/DecodeCsr.sv */
`default_nettype none

module DecodeCsr import DecodePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic cfgWrite,
    input  wire WordT cfgData,
    input  wire D_UOp uop [NUM_UOPS-1:0],
    output logic      mEnable,
    output CountT     undefCount
);

    localparam int LANE_W = $clog2(NUM_UOPS + 1);

    logic [LANE_W-1:0] undefLanes;
    logic [16:0]       countSum;

    // number of undefined lanes leaving the stage.
    always_comb begin
        undefLanes = '0;
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (uop[i].valid && uop[i].opcode == INT_UNDEFINED) begin
                undefLanes = undefLanes + 1'b1;
            end
        end
    end

    assign countSum = {1'b0, undefCount} + 17'(undefLanes); // bit 16 is overflow.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // config and status registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mEnable <= 1'b1;
            undefCount <= '0;
        end else if (cfgWrite) begin
            mEnable <= cfgData[0];
            undefCount <= '0; // any write restarts the count.
        end else if (countSum[16]) begin
            undefCount <= '1; // saturate.
        end else begin
            undefCount <= countSum[15:0];
        end
    end

endmodule

`default_nettype wire

/* hdl/DecodePkg.sv */
`default_nettype none

package DecodePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] WordT;     // pc, instruction, immediate.
    typedef logic [4:0]  RegIdxT;   // architectural register.
    typedef logic [3:0]  BranchIdT; // tag from the predictor.
    typedef logic [15:0] CountT;    // status counter.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // enums
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_MUL,
        FU_DIV
    } FuncUnitT;

    typedef enum logic [5:0] {
        INT_ADD,
        INT_SUB,
        INT_SLL,
        INT_SLT,
        INT_SLTU,
        INT_XOR,
        INT_SRL,
        INT_SRA,
        INT_OR,
        INT_AND,
        INT_LUI,
        INT_AUIPC,
        INT_JAL,
        INT_JALR,
        INT_SYS,
        INT_BEQ,
        INT_BNE,
        INT_BLT,
        INT_BGE,
        INT_BLTU,
        INT_BGEU,
        INT_UNDEFINED,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW,
        MUL_MUL,
        MUL_MULH,
        MUL_MULSU,
        MUL_MULU,
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } OpcodeT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // structs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [6:0] funct7;
        RegIdxT     rs1;
        RegIdxT     rs0;
        logic [2:0] funct3;
        RegIdxT     rd;
        logic [6:0] opcode;
    } Instr32;

    // decoded micro-op handed to rename.
    typedef struct packed {
        WordT     imm;        // absolute target for jal and branches.
        WordT     pc;
        RegIdxT   rs0;
        RegIdxT   rs1;
        RegIdxT   rd;
        OpcodeT   opcode;
        FuncUnitT fu;
        logic     pcA;        // operand a is the pc.
        logic     immB;       // operand b is the immediate.
        BranchIdT branchID;
        logic     branchPred;
        logic     valid;
    } D_UOp;

endpackage

`default_nettype wire

/* hdl/DecodeStage.sv */
`default_nettype none

module DecodeStage import DecodePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic flush,
    input  wire D_UOp decUop [NUM_UOPS-1:0],
    output D_UOp      uop    [NUM_UOPS-1:0]
);

    D_UOp uopQ   [NUM_UOPS-1:0];
    logic validQ [NUM_UOPS-1:0];

    // payload, loaded every cycle.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            uopQ[i] <= decUop[i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane valid bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                validQ[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                validQ[i] <= decUop[i].valid && !flush; // flush kills the whole group.
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            uop[i] = uopQ[i];
            uop[i].valid = validQ[i];
        end
    end

endmodule

`default_nettype wire

/* hdl/DecodeUnit.sv */
`default_nettype none

module DecodeUnit import DecodePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     flush,
    input  wire logic     cfgWrite,
    input  wire WordT     cfgData,
    input  wire WordT     instr      [NUM_UOPS-1:0],
    input  wire logic     instrValid [NUM_UOPS-1:0],
    input  wire logic     branchPred [NUM_UOPS-1:0],
    input  wire BranchIdT branchId   [NUM_UOPS-1:0],
    input  wire WordT     pc         [NUM_UOPS-1:0],
    output D_UOp          uop        [NUM_UOPS-1:0],
    output logic          mEnable,
    output CountT         undefCount
);

    D_UOp decUop [NUM_UOPS-1:0]; // combinational decode result.

    InstrDecoder #(
        .NUM_UOPS(NUM_UOPS)
    ) decoder0 (
        .instr(instr),
        .instrValid(instrValid),
        .branchPred(branchPred),
        .branchId(branchId),
        .pc(pc),
        .mEnable(mEnable),
        .uop(decUop)
    );

    DecodeStage #(
        .NUM_UOPS(NUM_UOPS)
    ) stage0 (
        .clk(clk),
        .rstN(rstN),
        .flush(flush),
        .decUop(decUop),
        .uop(uop)
    );

    // counts undefined ops as they leave the register.
    DecodeCsr #(
        .NUM_UOPS(NUM_UOPS)
    ) csr0 (
        .clk(clk),
        .rstN(rstN),
        .cfgWrite(cfgWrite),
        .cfgData(cfgData),
        .uop(uop),
        .mEnable(mEnable),
        .undefCount(undefCount)
    );

endmodule

`default_nettype wire

/* hdl/InstrDecoder.sv */
`default_nettype none

`include "rvOpcodes.svh"

module InstrDecoder import DecodePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  wire WordT     instr      [NUM_UOPS-1:0],
    input  wire logic     instrValid [NUM_UOPS-1:0],
    input  wire logic     branchPred [NUM_UOPS-1:0],
    input  wire BranchIdT branchId   [NUM_UOPS-1:0],
    input  wire WordT     pc         [NUM_UOPS-1:0],
    input  wire logic     mEnable,
    output D_UOp          uop        [NUM_UOPS-1:0]
);

    for (genvar i = 0; i < NUM_UOPS; i++) begin : gLane

        Instr32 ins;
        D_UOp   u;
        logic   invalidEnc;

        assign ins = instr[i];

        always_comb begin
            u = '0;
            invalidEnc = 1'b0;
            u.pc = pc[i];
            u.valid = instrValid[i];
            u.branchID = branchId[i];
            u.branchPred = branchPred[i];

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // immediate
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            case (ins.opcode)
                `OPC_LUI,
                `OPC_AUIPC:   u.imm = {instr[i][31:12], 12'b0};
                `OPC_JAL:     u.imm = pc[i] + {{12{instr[i][31]}}, instr[i][19:12],
                                               instr[i][20], instr[i][30:21], 1'b0};
                `OPC_BRANCH:  u.imm = pc[i] + {{20{instr[i][31]}}, instr[i][7],
                                               instr[i][30:25], instr[i][11:8], 1'b0};
                `OPC_JALR,
                `OPC_LOAD,
                `OPC_REG_IMM,
                `OPC_ENV:     u.imm = {{20{instr[i][31]}}, instr[i][31:20]};
                `OPC_STORE:   u.imm = {{20{instr[i][31]}}, instr[i][31:25], instr[i][11:7]};
                default:      u.imm = '0;
            endcase

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // unit, operation, registers
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            case (ins.opcode)
                `OPC_ENV: begin
                    u.fu = FU_INT;
                    u.opcode = INT_SYS;
                    u.pcA = 1'b1;
                    u.immB = 1'b1;
                end
                `OPC_LUI: begin
                    u.fu = FU_INT;
                    u.opcode = INT_LUI;
                    u.immB = 1'b1;
                    u.rd = ins.rd;
                end
                `OPC_AUIPC: begin
                    u.fu = FU_INT;
                    u.opcode = INT_AUIPC;
                    u.pcA = 1'b1;
                    u.immB = 1'b1;
                    u.rd = ins.rd;
                end
                `OPC_JAL: begin
                    u.fu = FU_INT;
                    u.opcode = INT_JAL;
                    u.pcA = 1'b1;
                    u.immB = 1'b1;
                    u.rd = ins.rd;
                end
                `OPC_JALR: begin
                    u.fu = FU_INT;
                    u.opcode = INT_JALR;
                    u.rs1 = ins.rs0; // base goes to srcB, pc to srcA.
                    u.pcA = 1'b1;
                    u.rd = ins.rd;
                end
                `OPC_LOAD: begin
                    u.fu = FU_LSU;
                    u.rs0 = ins.rs0;
                    u.immB = 1'b1;
                    u.rd = ins.rd;
                    case (ins.funct3)
                        3'd0:    u.opcode = LSU_LB;
                        3'd1:    u.opcode = LSU_LH;
                        3'd2:    u.opcode = LSU_LW;
                        3'd4:    u.opcode = LSU_LBU;
                        3'd5:    u.opcode = LSU_LHU;
                        default: invalidEnc = 1'b1;
                    endcase
                end
                `OPC_STORE: begin
                    u.fu = FU_LSU;
                    u.rs0 = ins.rs0;
                    u.rs1 = ins.rs1;
                    case (ins.funct3)
                        3'd0:    u.opcode = LSU_SB;
                        3'd1:    u.opcode = LSU_SH;
                        3'd2:    u.opcode = LSU_SW;
                        default: invalidEnc = 1'b1;
                    endcase
                end
                `OPC_BRANCH: begin
                    u.fu = FU_INT;
                    u.rs0 = ins.rs0;
                    u.rs1 = ins.rs1;
                    case (ins.funct3)
                        3'd0:    u.opcode = INT_BEQ;
                        3'd1:    u.opcode = INT_BNE;
                        3'd4:    u.opcode = INT_BLT;
                        3'd5:    u.opcode = INT_BGE;
                        3'd6:    u.opcode = INT_BLTU;
                        3'd7:    u.opcode = INT_BGEU;
                        default: invalidEnc = 1'b1;
                    endcase
                end
                `OPC_REG_IMM: begin
                    u.fu = FU_INT;
                    u.rs0 = ins.rs0;
                    u.immB = 1'b1;
                    u.rd = ins.rd;
                    case (ins.funct3)
                        3'd0: u.opcode = INT_ADD;
                        3'd1: begin
                            u.opcode = INT_SLL;
                            invalidEnc = (ins.funct7 != 7'h00);
                        end
                        3'd2: u.opcode = INT_SLT;
                        3'd3: u.opcode = INT_SLTU;
                        3'd4: u.opcode = INT_XOR;
                        3'd5: begin
                            u.opcode = (ins.funct7 == 7'h20) ? INT_SRA : INT_SRL;
                            invalidEnc = (ins.funct7 != 7'h00) && (ins.funct7 != 7'h20);
                        end
                        3'd6: u.opcode = INT_OR;
                        default: u.opcode = INT_AND;
                    endcase
                end
                `OPC_REG_REG: begin
                    u.rs0 = ins.rs0;
                    u.rs1 = ins.rs1;
                    u.rd = ins.rd;
                    if (ins.funct7 == 7'h00) begin
                        u.fu = FU_INT;
                        case (ins.funct3)
                            3'd0:    u.opcode = INT_ADD;
                            3'd1:    u.opcode = INT_SLL;
                            3'd2:    u.opcode = INT_SLT;
                            3'd3:    u.opcode = INT_SLTU;
                            3'd4:    u.opcode = INT_XOR;
                            3'd5:    u.opcode = INT_SRL;
                            3'd6:    u.opcode = INT_OR;
                            default: u.opcode = INT_AND;
                        endcase
                    end else if (ins.funct7 == 7'h01) begin
                        u.fu = (ins.funct3 < 3'd4) ? FU_MUL : FU_DIV;
                        invalidEnc = !mEnable; // M extension switched off.
                        case (ins.funct3)
                            3'd0:    u.opcode = MUL_MUL;
                            3'd1:    u.opcode = MUL_MULH;
                            3'd2:    u.opcode = MUL_MULSU;
                            3'd3:    u.opcode = MUL_MULU;
                            3'd4:    u.opcode = DIV_DIV;
                            3'd5:    u.opcode = DIV_DIVU;
                            3'd6:    u.opcode = DIV_REM;
                            default: u.opcode = DIV_REMU;
                        endcase
                    end else if (ins.funct7 == 7'h20) begin
                        u.fu = FU_INT;
                        u.opcode = (ins.funct3 == 3'd5) ? INT_SRA : INT_SUB;
                        invalidEnc = (ins.funct3 != 3'd0) && (ins.funct3 != 3'd5);
                    end else begin
                        invalidEnc = 1'b1;
                    end
                end
                default: invalidEnc = 1'b1;
            endcase

            if (invalidEnc) begin
                u.opcode = INT_UNDEFINED;
                u.fu = FU_INT;
            end
        end

        assign uop[i] = u;
    end

endmodule

`default_nettype wire

/* include/rvOpcodes.svh */
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 major opcodes, bits 6:0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_BRANCH   7'b1100011
`define OPC_REG_IMM  7'b0010011 // alu with immediate.
`define OPC_REG_REG  7'b0110011 // alu reg-reg, also M extension.
`define OPC_ENV      7'b1110011 // ecall, ebreak and csr space.

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module DecodeTb -o DecodeTbSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/DecodeTbSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

/* sim/DecodeChecker.sv */
`default_nettype none

`include "rvOpcodes.svh"

module DecodeChecker import DecodePkg::*; #(
    parameter int NUM_UOPS = 2
) (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     flush,
    input  wire logic     cfgWrite,
    input  wire WordT     cfgData,
    input  wire WordT     instr      [NUM_UOPS-1:0],
    input  wire logic     instrValid [NUM_UOPS-1:0],
    input  wire logic     branchPred [NUM_UOPS-1:0],
    input  wire BranchIdT branchId   [NUM_UOPS-1:0],
    input  wire WordT     pc         [NUM_UOPS-1:0],
    input  wire D_UOp     uop        [NUM_UOPS-1:0],
    input  wire logic     mEnable,
    input  wire CountT    undefCount,
    output int            errorCount,
    output int            checkCount
);

    D_UOp  expUop [NUM_UOPS-1:0]; // what the register should show now.
    D_UOp  nextUop;
    logic  modelMEn;
    CountT modelCount;
    int    undefSeen;
    int    countSum;
    int    errors = 0;
    int    checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference decoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic OpcodeT aluOp(input logic [2:0] f3);
        case (f3)
            3'd0:    return INT_ADD;
            3'd1:    return INT_SLL;
            3'd2:    return INT_SLT;
            3'd3:    return INT_SLTU;
            3'd4:    return INT_XOR;
            3'd5:    return INT_SRL;
            3'd6:    return INT_OR;
            default: return INT_AND;
        endcase
    endfunction

    function automatic OpcodeT mulDivOp(input logic [2:0] f3);
        case (f3)
            3'd0:    return MUL_MUL;
            3'd1:    return MUL_MULH;
            3'd2:    return MUL_MULSU;
            3'd3:    return MUL_MULU;
            3'd4:    return DIV_DIV;
            3'd5:    return DIV_DIVU;
            3'd6:    return DIV_REM;
            default: return DIV_REMU;
        endcase
    endfunction

    function automatic D_UOp modelDecode(input WordT w, input WordT pcIn, input logic v,
                                         input BranchIdT bid, input logic bp,
                                         input logic mEn);
        D_UOp       m;
        logic       bad;
        logic [2:0] f3;
        logic [6:0] f7;
        m = '0;
        bad = 1'b0;
        f3 = w[14:12];
        f7 = w[31:25];
        m.pc = pcIn;
        m.valid = v;
        m.branchID = bid;
        m.branchPred = bp;
        m.fu = FU_INT;
        case (w[6:0])
            `OPC_LUI: begin
                m.imm = {w[31:12], 12'h000};
                m.opcode = INT_LUI;
                m.immB = 1'b1;
                m.rd = w[11:7];
            end
            `OPC_AUIPC: begin
                m.imm = {w[31:12], 12'h000};
                m.opcode = INT_AUIPC;
                {m.pcA, m.immB} = 2'b11;
                m.rd = w[11:7];
            end
            `OPC_JAL: begin
                m.imm = pcIn + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                m.opcode = INT_JAL;
                {m.pcA, m.immB} = 2'b11;
                m.rd = w[11:7];
            end
            `OPC_JALR: begin
                m.imm = {{20{w[31]}}, w[31:20]};
                m.opcode = INT_JALR;
                m.pcA = 1'b1;
                m.rs1 = w[19:15]; // base register sits in the second slot.
                m.rd = w[11:7];
            end
            `OPC_LOAD: begin
                m.imm = {{20{w[31]}}, w[31:20]};
                m.fu = FU_LSU;
                m.immB = 1'b1;
                m.rs0 = w[19:15];
                m.rd = w[11:7];
                case (f3)
                    3'd0:    m.opcode = LSU_LB;
                    3'd1:    m.opcode = LSU_LH;
                    3'd2:    m.opcode = LSU_LW;
                    3'd4:    m.opcode = LSU_LBU;
                    3'd5:    m.opcode = LSU_LHU;
                    default: bad = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                m.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                m.fu = FU_LSU;
                m.rs0 = w[19:15];
                m.rs1 = w[24:20];
                m.opcode = (f3 == 3'd0) ? LSU_SB : (f3 == 3'd1) ? LSU_SH : LSU_SW;
                bad = (f3 > 3'd2);
            end
            `OPC_BRANCH: begin
                m.imm = pcIn + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                m.rs0 = w[19:15];
                m.rs1 = w[24:20];
                case (f3)
                    3'd0:    m.opcode = INT_BEQ;
                    3'd1:    m.opcode = INT_BNE;
                    3'd4:    m.opcode = INT_BLT;
                    3'd5:    m.opcode = INT_BGE;
                    3'd6:    m.opcode = INT_BLTU;
                    3'd7:    m.opcode = INT_BGEU;
                    default: bad = 1'b1;
                endcase
            end
            `OPC_REG_IMM: begin
                m.imm = {{20{w[31]}}, w[31:20]};
                m.immB = 1'b1;
                m.rs0 = w[19:15];
                m.rd = w[11:7];
                m.opcode = aluOp(f3);
                if (f3 == 3'd1) bad = (f7 != 7'h00);
                if (f3 == 3'd5) begin
                    bad = (f7 != 7'h00) && (f7 != 7'h20);
                    if (f7 == 7'h20) m.opcode = INT_SRA;
                end
            end
            `OPC_REG_REG: begin
                m.rs0 = w[19:15];
                m.rs1 = w[24:20];
                m.rd = w[11:7];
                if (f7 == 7'h00) begin
                    m.opcode = aluOp(f3);
                end else if (f7 == 7'h01) begin
                    m.opcode = mulDivOp(f3);
                    m.fu = f3[2] ? FU_DIV : FU_MUL;
                    bad = !mEn;
                end else if (f7 == 7'h20) begin
                    m.opcode = (f3 == 3'd5) ? INT_SRA : INT_SUB;
                    bad = (f3 != 3'd0) && (f3 != 3'd5);
                end else begin
                    bad = 1'b1;
                end
            end
            `OPC_ENV: begin
                m.imm = {{20{w[31]}}, w[31:20]};
                m.opcode = INT_SYS;
                {m.pcA, m.immB} = 2'b11;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            m.opcode = INT_UNDEFINED;
            m.fu = FU_INT;
        end
        return m;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model state, one cycle behind
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                expUop[i] <= '0;
            end
            modelMEn <= 1'b1;
            modelCount <= '0;
        end else begin
            undefSeen = 0;
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (expUop[i].valid && expUop[i].opcode == INT_UNDEFINED) undefSeen++;
                nextUop = modelDecode(instr[i], pc[i], instrValid[i], branchId[i],
                                      branchPred[i], modelMEn); // old enable applies.
                nextUop.valid = instrValid[i] && !flush;
                expUop[i] <= nextUop;
            end
            countSum = int'(modelCount) + undefSeen;
            if (cfgWrite) begin
                modelMEn <= cfgData[0];
                modelCount <= '0;
            end else begin
                modelCount <= (countSum > 65535) ? 16'hffff : CountT'(countSum);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareLane(input int i);
        D_UOp e;
        D_UOp a;
        e = expUop[i];
        a = uop[i];
        compareValue($sformatf("uop[%0d].imm", i), e.imm, a.imm);
        compareValue($sformatf("uop[%0d].pc", i), e.pc, a.pc);
        compareValue($sformatf("uop[%0d].rs0", i), 32'(e.rs0), 32'(a.rs0));
        compareValue($sformatf("uop[%0d].rs1", i), 32'(e.rs1), 32'(a.rs1));
        compareValue($sformatf("uop[%0d].rd", i), 32'(e.rd), 32'(a.rd));
        compareValue($sformatf("uop[%0d].opcode", i), 32'(e.opcode), 32'(a.opcode));
        compareValue($sformatf("uop[%0d].fu", i), 32'(e.fu), 32'(a.fu));
        compareValue($sformatf("uop[%0d].pcA", i), 32'(e.pcA), 32'(a.pcA));
        compareValue($sformatf("uop[%0d].immB", i), 32'(e.immB), 32'(a.immB));
        compareValue($sformatf("uop[%0d].branchID", i), 32'(e.branchID), 32'(a.branchID));
        compareValue($sformatf("uop[%0d].branchPred", i), 32'(e.branchPred),
                     32'(a.branchPred));
    endtask

    // outputs have settled by the falling edge.
    always @(negedge clk) begin
        compareValue("mEnable", 32'(modelMEn), 32'(mEnable));
        compareValue("undefCount", 32'(modelCount), 32'(undefCount));
        for (int i = 0; i < NUM_UOPS; i++) begin
            compareValue($sformatf("uop[%0d].valid", i), 32'(expUop[i].valid),
                         32'(uop[i].valid));
            if (expUop[i].valid) compareLane(i); // payload only matters when valid.
        end
    end

endmodule

`default_nettype wire

/* sim/DecodeTb.sv */
`default_nettype none

`include "rvOpcodes.svh"

module DecodeTb import DecodePkg::*;;

    localparam int NUM_UOPS     = 2;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 2000;
    localparam int MAX_CYCLES   = NUM_CYCLES + 100; // stimulus plus reset and drain slack.

    logic     clk;
    logic     rstN;
    logic     flush;
    logic     cfgWrite;
    WordT     cfgData;
    WordT     instr      [NUM_UOPS-1:0];
    logic     instrValid [NUM_UOPS-1:0];
    logic     branchPred [NUM_UOPS-1:0];
    BranchIdT branchId   [NUM_UOPS-1:0];
    WordT     pc         [NUM_UOPS-1:0];
    D_UOp     uop        [NUM_UOPS-1:0];
    logic     mEnable;
    CountT    undefCount;
    int       errorCount;
    int       checkCount;
    int       cycleCount = 0;

    logic [31:0] lfsrState = 32'h3b44_5b97;

    DecodeUnit #(
        .NUM_UOPS(NUM_UOPS)
    ) dut0 (
        .clk(clk),
        .rstN(rstN),
        .flush(flush),
        .cfgWrite(cfgWrite),
        .cfgData(cfgData),
        .instr(instr),
        .instrValid(instrValid),
        .branchPred(branchPred),
        .branchId(branchId),
        .pc(pc),
        .uop(uop),
        .mEnable(mEnable),
        .undefCount(undefCount)
    );

    DecodeChecker #(
        .NUM_UOPS(NUM_UOPS)
    ) checker0 (
        .clk(clk),
        .rstN(rstN),
        .flush(flush),
        .cfgWrite(cfgWrite),
        .cfgData(cfgData),
        .instr(instr),
        .instrValid(instrValid),
        .branchPred(branchPred),
        .branchId(branchId),
        .pc(pc),
        .uop(uop),
        .mEnable(mEnable),
        .undefCount(undefCount),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [6:0] majorOpcode(input int idx);
        case (idx)
            0:       return `OPC_LUI;
            1:       return `OPC_AUIPC;
            2:       return `OPC_JAL;
            3:       return `OPC_JALR;
            4:       return `OPC_LOAD;
            5:       return `OPC_STORE;
            6:       return `OPC_BRANCH;
            7:       return `OPC_REG_IMM;
            8:       return `OPC_REG_REG;
            default: return `OPC_ENV;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic makeInstr(output WordT word);
        logic [31:0] pick;
        logic [31:0] fields;
        logic [6:0]  opc;
        logic [6:0]  f7;
        takeBits(4, pick);
        if (pick < 10) begin
            opc = majorOpcode(int'(pick));
        end else begin
            takeBits(7, pick); // random opcodes are mostly unknown ones.
            opc = pick[6:0];
        end
        takeBits(2, pick);
        case (pick[1:0])
            2'd0: f7 = 7'h00;
            2'd1: f7 = 7'h01;
            2'd2: f7 = 7'h20;
            default: begin
                takeBits(7, pick);
                f7 = pick[6:0];
            end
        endcase
        takeBits(18, fields);
        word = {f7, fields[17:0], opc};
    endtask

    task automatic setIdle();
        flush = 1'b0;
        cfgWrite = 1'b0;
        cfgData = '0;
        for (int i = 0; i < NUM_UOPS; i++) begin
            instr[i] = '0;
            instrValid[i] = 1'b0;
            branchPred[i] = 1'b0;
            branchId[i] = '0;
            pc[i] = '0;
        end
    endtask

    task automatic driveCycle();
        logic [31:0] r;
        for (int i = 0; i < NUM_UOPS; i++) begin
            makeInstr(instr[i]);
            takeBits(2, r);
            instrValid[i] = (r[1:0] != 2'b00); // three lanes in four are valid.
            takeBits(1, r);
            branchPred[i] = r[0];
            takeBits(4, r);
            branchId[i] = r[3:0];
            takeBits(32, r);
            pc[i] = r;
        end
        takeBits(4, r);
        flush = (r[3:0] == 4'h0);
        takeBits(6, r);
        cfgWrite = (r[5:0] == 6'h00);
        if (cfgWrite) begin
            takeBits(32, r);
            cfgData = r;
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        setIdle();
        for (int i = 0; i < NUM_UOPS; i++) begin
            instrValid[i] = 1'b1; // only the reset keeps these lanes empty.
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            driveCycle();
            @(negedge clk);
        end
        setIdle();
        repeat (2) @(negedge clk);
        #1;
        $display("checker summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("Test completed successfully");
        end else begin
            if (checkCount == 0) begin
                $display("no comparison was made during the run");
            end
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/DecodePkg.sv
hdl/InstrDecoder.sv
hdl/DecodeStage.sv
hdl/DecodeCsr.sv
hdl/DecodeUnit.sv
sim/DecodeChecker.sv
sim/DecodeTb.sv
